//--- hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int T_W        = 3;

    localparam logic [XLEN-1:0]       PC_RESET = 32'h00003000;
    localparam logic [REG_ADDR_W-1:0] RA_REG   = 5'd31;

    typedef logic [REG_ADDR_W-1:0] regNum_t;
    typedef logic [XLEN-1:0]       word_t;

    typedef enum logic [3:0] {
        OP_NOP,   // must stay zero, bubbles rely on it
        OP_ADDU,
        OP_SUBU,
        OP_ORI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_JAL,
        OP_JR
    } opcode_t;

    typedef enum logic [1:0] {
        SRC_ALU,
        SRC_MEM,
        SRC_PC8
    } regSrc_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_FROM_E,
        FWD_FROM_M,
        FWD_FROM_W
    } fwdSel_t;

    typedef struct packed {
        opcode_t               op;
        logic                  regWrite;
        regNum_t               writeNum;
        regSrc_t               regSrc;
        logic                  useImm;
        logic                  memWrite;
        logic signed [T_W-1:0] tUseRs;
        logic signed [T_W-1:0] tUseRt;
        logic signed [T_W-1:0] tNew;   // counted from decode
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fdReg_t;

    typedef struct packed {
        word_t   pc;
        regNum_t rs;
        regNum_t rt;
        word_t   rsData;
        word_t   rtData;
        word_t   imm;
        ctrl_t   ctrl;
    } deReg_t;

    typedef struct packed {
        word_t   pc;
        regNum_t rt;
        word_t   rtData;
        word_t   aluResult;
        ctrl_t   ctrl;
    } emReg_t;

    typedef struct packed {
        word_t pc;
        word_t aluResult;
        word_t memData;
        ctrl_t ctrl;
    } mwReg_t;

endpackage

`default_nettype wire

//--- hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire cpuPkg::word_t instr,
    output cpuPkg::ctrl_t      ctrl,
    output cpuPkg::word_t      imm
);
    import cpuPkg::*;

    logic [5:0] opField;
    logic [5:0] funct;
    regNum_t    rt;
    regNum_t    rd;
    opcode_t    op;

    assign opField = instr[31:26];
    assign funct   = instr[5:0];
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];

    always_comb begin
        case (opField)
            6'b000000: begin
                case (funct)
                    6'b100001: op = OP_ADDU;
                    6'b100011: op = OP_SUBU;
                    6'b001000: op = OP_JR;
                    default:   op = OP_NOP;   // sll and unknown funct
                endcase
            end
            6'b001101: op = OP_ORI;
            6'b001111: op = OP_LUI;
            6'b100011: op = OP_LW;
            6'b101011: op = OP_SW;
            6'b000100: op = OP_BEQ;
            6'b000011: op = OP_JAL;
            default:   op = OP_NOP;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.op     = op;
        ctrl.tUseRs = 3'sd3;   // operand not read
        ctrl.tUseRt = 3'sd3;
        case (op)
            OP_ADDU, OP_SUBU: begin
                ctrl.regWrite = 1'b1;
                ctrl.writeNum = rd;
                ctrl.tUseRs   = 3'sd1;
                ctrl.tUseRt   = 3'sd1;
                ctrl.tNew     = 3'sd2;
            end
            OP_ORI, OP_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.writeNum = rt;
                ctrl.useImm   = 1'b1;
                ctrl.tUseRs   = (op == OP_ORI) ? 3'sd1 : 3'sd3;   // lui ignores rs
                ctrl.tNew     = 3'sd2;
            end
            OP_LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.writeNum = rt;
                ctrl.regSrc   = SRC_MEM;
                ctrl.useImm   = 1'b1;
                ctrl.tUseRs   = 3'sd1;
                ctrl.tNew     = 3'sd3;
            end
            OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.tUseRs   = 3'sd1;
                ctrl.tUseRt   = 3'sd2;   // data needed only in memory
            end
            OP_BEQ: begin
                ctrl.tUseRs = 3'sd0;
                ctrl.tUseRt = 3'sd0;
            end
            OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.writeNum = RA_REG;
                ctrl.regSrc   = SRC_PC8;
                ctrl.tNew     = 3'sd1;
            end
            OP_JR: ctrl.tUseRs = 3'sd0;
            default: ;
        endcase
    end

    always_comb begin
        case (op)
            OP_ORI:               imm = {16'b0, instr[15:0]};
            OP_LUI:               imm = {instr[15:0], 16'b0};
            OP_LW, OP_SW, OP_BEQ: imm = {{16{instr[15]}}, instr[15:0]};
            default:              imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire cpuPkg::regNum_t rdNum1,
    input  wire cpuPkg::regNum_t rdNum2,
    input  wire                  wrEn,
    input  wire cpuPkg::regNum_t wrNum,
    input  wire cpuPkg::word_t   wrData,
    output cpuPkg::word_t        rdData1,
    output cpuPkg::word_t        rdData2
);
    import cpuPkg::*;

    word_t regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrNum != '0) begin
            regs[wrNum] <= wrData;
        end
    end

    // writeback bypass into decode
    assign rdData1 = (rdNum1 == '0) ? '0 : (wrEn && wrNum == rdNum1) ? wrData : regs[rdNum1];
    assign rdData2 = (rdNum2 == '0) ? '0 : (wrEn && wrNum == rdNum2) ? wrData : regs[rdNum2];

endmodule

`default_nettype wire

//--- hdl/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire cpuPkg::regNum_t dRs,
    input  wire cpuPkg::regNum_t dRt,
    input  wire cpuPkg::ctrl_t   dCtrl,
    input  wire cpuPkg::regNum_t eRs,
    input  wire cpuPkg::regNum_t eRt,
    input  wire cpuPkg::ctrl_t   eCtrl,
    input  wire cpuPkg::regNum_t mRt,
    input  wire cpuPkg::ctrl_t   mCtrl,
    input  wire cpuPkg::ctrl_t   wCtrl,
    output logic                 stall,
    output cpuPkg::fwdSel_t      fwdDRs,
    output cpuPkg::fwdSel_t      fwdDRt,
    output cpuPkg::fwdSel_t      fwdERs,
    output cpuPkg::fwdSel_t      fwdERt,
    output cpuPkg::fwdSel_t      fwdMRt
);
    import cpuPkg::*;

    logic signed [T_W-1:0] eRem;
    logic signed [T_W-1:0] mRem;

    // cycles left once the instruction is age stages past decode
    function automatic logic signed [T_W-1:0] remain(input ctrl_t c,
                                                     input logic signed [T_W-1:0] age);
        logic signed [T_W-1:0] r;
        r = c.tNew - age;
        return (r < 0) ? '0 : r;
    endfunction

    function automatic logic hits(input ctrl_t c, input regNum_t r);
        return c.regWrite && (c.writeNum == r) && (r != '0);
    endfunction

    // the younger stage shadows the older one even when not yet ready
    function automatic fwdSel_t choose(input logic hitA, input logic readyA, input fwdSel_t selA,
                                       input logic hitB, input logic readyB, input fwdSel_t selB);
        if (hitA) begin
            return readyA ? selA : FWD_NONE;
        end
        if (hitB && readyB) begin
            return selB;
        end
        return FWD_NONE;
    endfunction

    assign eRem = remain(eCtrl, 3'sd1);
    assign mRem = remain(mCtrl, 3'sd2);

    assign stall = (hits(eCtrl, dRs) && (eRem > dCtrl.tUseRs)) ||
                   (hits(eCtrl, dRt) && (eRem > dCtrl.tUseRt)) ||
                   (hits(mCtrl, dRs) && (mRem > dCtrl.tUseRs)) ||
                   (hits(mCtrl, dRt) && (mRem > dCtrl.tUseRt));

    assign fwdDRs = choose(hits(eCtrl, dRs), eRem == 0, FWD_FROM_E,
                           hits(mCtrl, dRs), mRem == 0, FWD_FROM_M);
    assign fwdDRt = choose(hits(eCtrl, dRt), eRem == 0, FWD_FROM_E,
                           hits(mCtrl, dRt), mRem == 0, FWD_FROM_M);
    assign fwdERs = choose(hits(mCtrl, eRs), mRem == 0, FWD_FROM_M,
                           hits(wCtrl, eRs), 1'b1, FWD_FROM_W);   // writeback always ready
    assign fwdERt = choose(hits(mCtrl, eRt), mRem == 0, FWD_FROM_M,
                           hits(wCtrl, eRt), 1'b1, FWD_FROM_W);
    assign fwdMRt = choose(hits(wCtrl, mRt), 1'b1, FWD_FROM_W,
                           1'b0, 1'b0, FWD_NONE);

endmodule

`default_nettype wire

//--- hdl/branchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module branchUnit (
    input  wire cpuPkg::word_t fPc,
    input  wire cpuPkg::word_t dPc,
    input  wire cpuPkg::ctrl_t dCtrl,
    input  wire cpuPkg::word_t dInstr,
    input  wire cpuPkg::word_t rsData,
    input  wire cpuPkg::word_t rtData,
    input  wire cpuPkg::word_t imm,
    output cpuPkg::word_t      nextPc
);
    import cpuPkg::*;

    logic  equal;
    word_t seqPc;
    word_t branchTarget;

    assign equal        = (rsData == rtData);
    assign seqPc        = fPc + 32'd4;
    assign branchTarget = dPc + 32'd4 + {imm[XLEN-3:0], 2'b00};

    always_comb begin
        case (dCtrl.op)
            OP_BEQ:  nextPc = equal ? branchTarget : seqPc;
            OP_JAL:  nextPc = {fPc[31:28], dInstr[25:0], 2'b00};   // fPc is the delay slot
            OP_JR:   nextPc = rsData;
            default: nextPc = seqPc;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire cpuPkg::word_t   a,
    input  wire cpuPkg::word_t   b,
    input  wire cpuPkg::opcode_t op,
    output cpuPkg::word_t        y
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            OP_ADDU, OP_LW, OP_SW: y = a + b;   // address calc too
            OP_SUBU:               y = a - b;
            OP_ORI:                y = a | b;
            OP_LUI:                y = b;       // imm already shifted
            default:               y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
    input  wire                  clk,
    input  wire                  rstN,
    output cpuPkg::word_t        imAddr,
    input  wire cpuPkg::word_t   imData,
    output cpuPkg::word_t        dmAddr,
    output cpuPkg::word_t        dmWriteData,
    output logic                 dmWriteEn,
    input  wire cpuPkg::word_t   dmReadData,
    output logic                 grfWriteEn,
    output cpuPkg::regNum_t      grfWriteNum,
    output cpuPkg::word_t        grfWriteData,
    output cpuPkg::word_t        grfPc
);
    import cpuPkg::*;

    word_t   pc;
    word_t   nextPc;
    fdReg_t  fd;
    deReg_t  de;
    emReg_t  em;
    mwReg_t  mw;

    ctrl_t   dCtrl;
    word_t   dImm;
    regNum_t dRs;
    regNum_t dRt;
    word_t   dRsRaw;
    word_t   dRtRaw;
    word_t   dRsData;
    word_t   dRtData;

    word_t   eRsData;
    word_t   eRtData;
    word_t   aluB;
    word_t   aluY;
    word_t   mRtData;

    word_t   eFwd;
    word_t   mFwd;
    word_t   wData;

    logic    stall;
    fwdSel_t fwdDRs;
    fwdSel_t fwdDRt;
    fwdSel_t fwdERs;
    fwdSel_t fwdERt;
    fwdSel_t fwdMRt;

    function automatic word_t pickFwd(input fwdSel_t sel, input word_t raw,
                                      input word_t fromE, input word_t fromM,
                                      input word_t fromW);
        case (sel)
            FWD_FROM_E: return fromE;
            FWD_FROM_M: return fromM;
            FWD_FROM_W: return fromW;
            default:    return raw;
        endcase
    endfunction

    // fetch
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= PC_RESET;
            fd <= '0;
        end else if (!stall) begin
            pc <= nextPc;
            fd <= '{pc: pc, instr: imData};
        end
    end

    assign imAddr = pc;

    // decode
    assign dRs = fd.instr[25:21];
    assign dRt = fd.instr[20:16];

    decoder uDecoder (
        .instr(fd.instr),
        .ctrl (dCtrl),
        .imm  (dImm)
    );

    regFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .rdNum1 (dRs),
        .rdNum2 (dRt),
        .wrEn   (grfWriteEn),
        .wrNum  (grfWriteNum),
        .wrData (wData),
        .rdData1(dRsRaw),
        .rdData2(dRtRaw)
    );

    hazardUnit uHazard (
        .dRs   (dRs),
        .dRt   (dRt),
        .dCtrl (dCtrl),
        .eRs   (de.rs),
        .eRt   (de.rt),
        .eCtrl (de.ctrl),
        .mRt   (em.rt),
        .mCtrl (em.ctrl),
        .wCtrl (mw.ctrl),
        .stall (stall),
        .fwdDRs(fwdDRs),
        .fwdDRt(fwdDRt),
        .fwdERs(fwdERs),
        .fwdERt(fwdERt),
        .fwdMRt(fwdMRt)
    );

    assign eFwd = de.pc + 32'd8;   // only jal is ready this early
    assign mFwd = (em.ctrl.regSrc == SRC_PC8) ? em.pc + 32'd8 : em.aluResult;

    assign dRsData = pickFwd(fwdDRs, dRsRaw, eFwd, mFwd, wData);
    assign dRtData = pickFwd(fwdDRt, dRtRaw, eFwd, mFwd, wData);

    branchUnit uBranch (
        .fPc   (pc),
        .dPc   (fd.pc),
        .dCtrl (dCtrl),
        .dInstr(fd.instr),
        .rsData(dRsData),
        .rtData(dRtData),
        .imm   (dImm),
        .nextPc(nextPc)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            de <= '0;
        end else if (stall) begin
            de <= '0;   // bubble
        end else begin
            de <= '{pc: fd.pc, rs: dRs, rt: dRt, rsData: dRsData, rtData: dRtData,
                    imm: dImm, ctrl: dCtrl};
        end
    end

    // execute
    assign eRsData = pickFwd(fwdERs, de.rsData, eFwd, mFwd, wData);
    assign eRtData = pickFwd(fwdERt, de.rtData, eFwd, mFwd, wData);
    assign aluB    = de.ctrl.useImm ? de.imm : eRtData;

    alu uAlu (
        .a (eRsData),
        .b (aluB),
        .op(de.ctrl.op),
        .y (aluY)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            em <= '0;
        end else begin
            em <= '{pc: de.pc, rt: de.rt, rtData: eRtData, aluResult: aluY, ctrl: de.ctrl};
        end
    end

    // memory
    assign mRtData     = pickFwd(fwdMRt, em.rtData, eFwd, mFwd, wData);
    assign dmAddr      = em.aluResult;
    assign dmWriteData = mRtData;
    assign dmWriteEn   = em.ctrl.memWrite;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mw <= '0;
        end else begin
            mw <= '{pc: em.pc, aluResult: em.aluResult, memData: dmReadData, ctrl: em.ctrl};
        end
    end

    // writeback
    always_comb begin
        case (mw.ctrl.regSrc)
            SRC_MEM: wData = mw.memData;
            SRC_PC8: wData = mw.pc + 32'd8;
            default: wData = mw.aluResult;
        endcase
    end

    assign grfWriteEn   = mw.ctrl.regWrite && (mw.ctrl.writeNum != '0);
    assign grfWriteNum  = mw.ctrl.writeNum;
    assign grfWriteData = wData;
    assign grfPc        = mw.pc;

endmodule

`default_nettype wire

//--- bench/cpuChecker.sv
`timescale 1ns/1ps
`default_nettype none

module cpuChecker (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire                  grfWriteEn,
    input  wire cpuPkg::regNum_t grfWriteNum,
    input  wire cpuPkg::word_t   grfWriteData,
    input  wire cpuPkg::word_t   grfPc,
    input  wire                  dmWriteEn,
    input  wire cpuPkg::word_t   dmAddr,
    input  wire cpuPkg::word_t   dmWriteData,
    input  wire signed [31:0]    expCount,
    input  wire signed [31:0]    expRow,
    input  wire cpuPkg::regNum_t expNum,
    input  wire cpuPkg::word_t   expValue,
    input  wire [2:0]            expGroup,
    input  wire                  expLast,
    input  wire signed [31:0]    expStores,
    input  wire cpuPkg::word_t   expStoreAddr,
    input  wire cpuPkg::word_t   expStoreData,
    output int                   writeIdx,
    output int                   storeIdx,
    output int                   errCount,
    output int                   checkCount,
    output logic                 done
);
    import cpuPkg::*;

    int    groupErrs;
    word_t expPc;

    assign expPc = PC_RESET + (expRow * 4);   // one word per table row
    assign done  = (expCount > 0) && (writeIdx >= expCount) && (storeIdx >= expStores);

    task automatic compareWord(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("error: %0t ns %s expected %h got %h", $time, name, expected, actual);
            errCount++;
            groupErrs++;
        end
    endtask

    // trace is registered, so the falling edge sees it settled
    always @(negedge clk) begin
        if (!rstN) begin
            writeIdx   = 0;
            storeIdx   = 0;
            errCount   = 0;
            checkCount = 0;
            groupErrs  = 0;
        end else begin
            if (dmWriteEn) begin
                if (storeIdx >= expStores) begin
                    $display("%0t ns: unexpected store of %h to address %h",
                             $time, dmWriteData, dmAddr);
                    errCount++;
                end else begin
                    compareWord("dmAddr", expStoreAddr, dmAddr);
                    compareWord("dmWriteData", expStoreData, dmWriteData);
                    storeIdx++;
                end
            end
            if (grfWriteEn) begin
                if (writeIdx >= expCount) begin
                    $display("%0t ns: unexpected write of %h to register %0d from pc %h",
                             $time, grfWriteData, grfWriteNum, grfPc);
                    $display("    it came after the last expected write");
                    errCount++;
                end else begin
                    checkCount++;
                    compareWord("grfPc", expPc, grfPc);
                    compareWord("grfWriteNum", word_t'(expNum), word_t'(grfWriteNum));
                    compareWord("grfWriteData", expValue, grfWriteData);
                    if (expLast) begin
                        $display("test %0d finished with %0d errors", expGroup, groupErrs);
                        groupErrs = 0;
                    end
                    writeIdx++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
    import cpuPkg::*;

    localparam int MAX_ROWS  = 64;
    localparam int MEM_WORDS = 1024;

    localparam logic [5:0] OPC_ORI = 6'b001101;
    localparam logic [5:0] OPC_LUI = 6'b001111;
    localparam logic [5:0] OPC_LW  = 6'b100011;
    localparam logic [5:0] OPC_SW  = 6'b101011;
    localparam logic [5:0] OPC_BEQ = 6'b000100;
    localparam logic [5:0] OPC_JAL = 6'b000011;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_JR   = 6'b001000;

    typedef struct packed {
        word_t      instr;
        logic       writes;
        regNum_t    num;
        word_t      value;
        logic [2:0] group;
    } row_t;

    logic    clk;
    logic    rstN;
    word_t   imAddr;
    word_t   imData;
    word_t   imOffset;
    word_t   dmAddr;
    word_t   dmWriteData;
    logic    dmWriteEn;
    word_t   dmReadData;
    logic    grfWriteEn;
    regNum_t grfWriteNum;
    word_t   grfWriteData;
    word_t   grfPc;

    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];
    row_t  rows [MAX_ROWS];
    int    wrRow [MAX_ROWS];
    logic  wrLast [MAX_ROWS];
    word_t storeAddr [MAX_ROWS];
    word_t storeData [MAX_ROWS];
    int    nRows;
    int    nWrites;
    int    nStores;
    int    cycles;
    int    limit;

    int    writeIdx;
    int    storeIdx;
    int    errCount;
    int    checkCount;
    logic  done;
    int    expRow;

    function automatic word_t rFormat(input regNum_t rs, input regNum_t rt, input regNum_t rd,
                                      input logic [5:0] funct);
        return {6'b000000, rs, rt, rd, 5'b00000, funct};
    endfunction

    function automatic word_t iFormat(input logic [5:0] opc, input regNum_t rs, input regNum_t rt,
                                      input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic word_t jFormat(input logic [5:0] opc, input word_t target);
        return {opc, target[27:2]};
    endfunction

    // every word differs and depends on the full index
    function automatic word_t memFill(input int idx);
        return 32'h5a5a0000 ^ (idx * 32'h00010003);
    endfunction

    task automatic addRow(input word_t instr, input logic writes, input regNum_t num,
                          input word_t value, input logic [2:0] group);
        rows[nRows] = '{instr: instr, writes: writes, num: num, value: value, group: group};
        nRows++;
    endtask

    task automatic addStore(input word_t addr, input word_t data);
        storeAddr[nStores] = addr;
        storeData[nStores] = data;
        nStores++;
    endtask

    task automatic buildProgram();
        addRow(iFormat(OPC_ORI, 0, 1, 16'h1234), 1, 1, 32'h00001234, 1);
        addRow(iFormat(OPC_LUI, 0, 2, 16'habcd), 1, 2, 32'habcd0000, 1);
        addRow(iFormat(OPC_ORI, 0, 3, 16'h00ff), 1, 3, 32'h000000ff, 1);
        addRow(iFormat(OPC_ORI, 0, 4, 16'h0f00), 1, 4, 32'h00000f00, 1);
        addRow(32'h0, 0, 0, 0, 1);
        addRow(32'h0, 0, 0, 0, 1);
        addRow(32'h0, 0, 0, 0, 1);
        addRow(rFormat(1, 2, 5, FN_ADDU), 1, 5, 32'h00001234 + 32'habcd0000, 1);
        addRow(rFormat(3, 4, 6, FN_SUBU), 1, 6, 32'h000000ff - 32'h00000f00, 1);
        // back to back dependences
        addRow(iFormat(OPC_ORI, 0, 7, 16'h0005), 1, 7, 32'd5, 2);
        addRow(rFormat(7, 7, 8, FN_ADDU), 1, 8, 32'd10, 2);
        addRow(rFormat(8, 7, 9, FN_ADDU), 1, 9, 32'd15, 2);
        addRow(rFormat(9, 8, 10, FN_SUBU), 1, 10, 32'd5, 2);
        addRow(iFormat(OPC_ORI, 10, 10, 16'h0030), 1, 10, 32'h35, 2);
        // load then use
        addRow(iFormat(OPC_LW, 0, 11, 16'h0040), 1, 11, memFill(16), 3);
        addRow(rFormat(11, 7, 12, FN_ADDU), 1, 12, memFill(16) + 32'd5, 3);
        addRow(iFormat(OPC_ORI, 0, 13, 16'h0080), 1, 13, 32'h80, 4);
        addRow(iFormat(OPC_SW, 13, 9, 16'h0004), 0, 0, 0, 4);
        addStore(32'h00000084, 32'd15);
        addRow(iFormat(OPC_LW, 13, 14, 16'h0004), 1, 14, 32'd15, 4);
        // 5 vs 0x35 so not taken
        addRow(iFormat(OPC_BEQ, 7, 10, 16'h0002), 0, 0, 0, 5);
        addRow(iFormat(OPC_ORI, 0, 15, 16'h0011), 1, 15, 32'h11, 5);
        addRow(iFormat(OPC_ORI, 0, 16, 16'h0022), 1, 16, 32'h22, 5);
        addRow(iFormat(OPC_BEQ, 15, 15, 16'h0002), 0, 0, 0, 5);
        addRow(iFormat(OPC_ORI, 0, 17, 16'h0033), 1, 17, 32'h33, 5);
        addRow(iFormat(OPC_ORI, 0, 18, 16'h0044), 0, 0, 0, 5);   // branched over
        addRow(iFormat(OPC_ORI, 0, 19, 16'h0055), 1, 19, 32'h55, 5);
        // call at row 26, subroutine at row 32
        addRow(jFormat(OPC_JAL, PC_RESET + 32 * 4), 1, RA_REG, PC_RESET + 26 * 4 + 8, 6);
        addRow(iFormat(OPC_ORI, 0, 20, 16'h0066), 1, 20, 32'h66, 6);
        addRow(iFormat(OPC_LW, 0, 21, 16'h0100), 1, 21, 32'h66, 6);   // stored by subroutine
        addRow(rFormat(RA_REG, 0, 22, FN_ADDU), 1, 22, PC_RESET + 26 * 4 + 8, 6);
        addRow(iFormat(OPC_BEQ, 0, 0, 16'hffff), 0, 0, 0, 6);   // park here
        addRow(32'h0, 0, 0, 0, 6);
        addRow(iFormat(OPC_SW, 0, 20, 16'h0100), 0, 0, 0, 6);
        addStore(32'h00000100, 32'h66);
        addRow(rFormat(RA_REG, 0, 0, FN_JR), 0, 0, 0, 6);
        addRow(32'h0, 0, 0, 0, 6);
    endtask

    cpuTop UUT (
        .clk         (clk),
        .rstN        (rstN),
        .imAddr      (imAddr),
        .imData      (imData),
        .dmAddr      (dmAddr),
        .dmWriteData (dmWriteData),
        .dmWriteEn   (dmWriteEn),
        .dmReadData  (dmReadData),
        .grfWriteEn  (grfWriteEn),
        .grfWriteNum (grfWriteNum),
        .grfWriteData(grfWriteData),
        .grfPc       (grfPc)
    );

    assign expRow = wrRow[writeIdx];

    cpuChecker uChecker (
        .clk         (clk),
        .rstN        (rstN),
        .grfWriteEn  (grfWriteEn),
        .grfWriteNum (grfWriteNum),
        .grfWriteData(grfWriteData),
        .grfPc       (grfPc),
        .dmWriteEn   (dmWriteEn),
        .dmAddr      (dmAddr),
        .dmWriteData (dmWriteData),
        .expCount    (nWrites),
        .expRow      (expRow),
        .expNum      (rows[expRow].num),
        .expValue    (rows[expRow].value),
        .expGroup    (rows[expRow].group),
        .expLast     (wrLast[writeIdx]),
        .expStores   (nStores),
        .expStoreAddr(storeAddr[storeIdx]),
        .expStoreData(storeData[storeIdx]),
        .writeIdx    (writeIdx),
        .storeIdx    (storeIdx),
        .errCount    (errCount),
        .checkCount  (checkCount),
        .done        (done)
    );

    assign imOffset   = imAddr - PC_RESET;
    assign imData     = imem[imOffset[11:2]];
    assign dmReadData = dmem[dmAddr[11:2]];

    always @(posedge clk) begin
        if (dmWriteEn) begin
            dmem[dmAddr[11:2]] <= dmWriteData;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rstN    = 1'b0;
        nRows   = 0;
        nWrites = 0;
        nStores = 0;
        buildProgram();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = memFill(i);
        end
        for (int i = 0; i < nRows; i++) begin
            imem[i] = rows[i].instr;
            if (rows[i].writes) begin
                wrRow[nWrites] = i;
                nWrites++;
            end
        end
        for (int k = 0; k < nWrites; k++) begin
            wrLast[k] = (k == nWrites - 1) || (rows[wrRow[k + 1]].group != rows[wrRow[k]].group);
        end
        limit = 4 * nRows + 50;

        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;

        cycles = 0;
        while (!done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end

        if (!done) begin
            $display("timeout after %0d cycles, %0d of %0d expected register writes never arrived",
                     cycles, nWrites - writeIdx, nWrites);
            for (int k = writeIdx; k < nWrites; k++) begin
                $display("    missing write of register %0d from pc %h",
                         rows[wrRow[k]].num, PC_RESET + wrRow[k] * 4);
            end
            if (storeIdx < nStores) begin
                $display("    %0d of %0d expected stores never arrived",
                         nStores - storeIdx, nStores);
            end
            $display("Regression failed");
        end else begin
            repeat (8) @(posedge clk);   // catch stray writes
            $display("%0d writes and %0d stores checked, %0d errors",
                     checkCount, storeIdx, errCount);
            if (errCount == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hdl/cpuPkg.sv
hdl/decoder.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/branchUnit.sv
hdl/alu.sv
hdl/cpuTop.sv
bench/cpuChecker.sv
bench/cpuTb.sv
